// ==== Makefile ====
# Verilator build and run of the bimodal predictor testbench.
TOP       ?= bimodalPredictorTb
SEED      ?= 39104
LOG       ?= sim.log
VERILATOR ?= verilator

FILELIST  := bimodalPredictor.f
OBJDIR    := obj_dir
FAIL_MSG  := Something failed
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "Variables: TOP=$(TOP) SEED=$(SEED) LOG=$(LOG) VERILATOR=$(VERILATOR)"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -GRANDOM_SEED=$(SEED) \
		--Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)."; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)."; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bimodalPredictor.f ====
+incdir+tests
source/bimodalPkg.sv
source/phtUpdateResolver.sv
source/phtUpdateQueue.sv
source/phtBank.sv
source/bimodalPredictor.sv
tests/bimodalPredictorTb.sv

// ==== source/bimodalPkg.sv ====
/*
 * Shared definitions for the bimodal branch predictor:
 * widths, table and queue sizes, counter typedefs,
 * the initialization state enum and the PC to index mapping.
 */

package bimodalPkg;

    // Fetch and resolve bandwidth.
    localparam int FETCH_WIDTH   = 2;
    localparam int RESOLVE_WIDTH = 2;

    // Address and table geometry.
    localparam int PC_WIDTH        = 32;
    localparam int INSN_BYTES      = 4;
    localparam int PHT_ENTRY_NUM   = 256;
    localparam int PHT_INDEX_WIDTH = $clog2(PHT_ENTRY_NUM);
    localparam int PHT_INDEX_LSB   = 2;

    // Two-bit saturating counter.
    localparam int COUNTER_WIDTH = 2;
    localparam int COUNTER_MAX   = 3;
    localparam int COUNTER_INIT  = 2;

    // Deferred update buffer.
    localparam int QUEUE_DEPTH     = 4;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);

    typedef logic [PC_WIDTH-1:0]        pcT;
    typedef logic [PHT_INDEX_WIDTH-1:0] phtIndexT;
    typedef logic [COUNTER_WIDTH-1:0]   phtCounterT;
    typedef logic [QUEUE_PTR_WIDTH-1:0] queuePtrT;

    typedef enum logic {
        INIT_RUN,
        INIT_DONE
    } initStateT;

    // Table index is taken from PC bits 9..2.
    function automatic phtIndexT phtIndexOf(input pcT pc);
        return pc[PHT_INDEX_LSB +: PHT_INDEX_WIDTH];
    endfunction

endpackage

// ==== source/bimodalPredictor.sv ====
/*
 * Bimodal predictor top: update resolver, deferred
 * update queue and counter table.
 */

`timescale 1ns/1ps

module bimodalPredictor
    import bimodalPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  pcT         predPc,
    input  logic       btbHit [FETCH_WIDTH],
    input  logic       brValid [RESOLVE_WIDTH],
    input  pcT         brPc [RESOLVE_WIDTH],
    input  logic       brTaken [RESOLVE_WIDTH],
    input  logic       brMispred [RESOLVE_WIDTH],
    input  phtCounterT brPrevCounter [RESOLVE_WIDTH],
    output logic       predTaken [FETCH_WIDTH],
    output phtCounterT predCounter [FETCH_WIDTH],
    output logic       initDone
);

    // Resolver to table.
    logic       directWe;
    phtIndexT   directIndex;
    phtCounterT directCounter;

    // Resolver to queue.
    logic       pushEn;
    phtIndexT   pushIndex;
    phtCounterT pushCounter;

    // Queue and table handshake.
    logic       popEn;
    logic       queueEmpty;
    phtIndexT   headIndex;
    phtCounterT headCounter;

    phtUpdateResolver i_phtUpdateResolver (
        .clk, .arstN, .initDone,
        .brValid, .brPc, .brTaken, .brMispred, .brPrevCounter,
        .directWe, .directIndex, .directCounter,
        .pushEn, .pushIndex, .pushCounter
    );

    phtUpdateQueue i_phtUpdateQueue (
        .clk, .arstN,
        .pushEn, .pushIndex, .pushCounter,
        .popEn,
        .queueEmpty, .headIndex, .headCounter
    );

    phtBank i_phtBank (
        .clk, .arstN,
        .predPc, .btbHit,
        .directWe, .directIndex, .directCounter,
        .queueEmpty, .headIndex, .headCounter,
        .popEn,
        .predTaken, .predCounter, .initDone
    );

endmodule

// ==== source/phtBank.sv ====
/*
 * Pattern history table: 256 two-bit counters, two registered
 * prediction reads, single write port arbitration and the
 * post-reset initialization sequence.
 */

`timescale 1ns/1ps

module phtBank
    import bimodalPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  pcT         predPc,
    input  logic       btbHit [FETCH_WIDTH],
    input  logic       directWe,
    input  phtIndexT   directIndex,
    input  phtCounterT directCounter,
    input  logic       queueEmpty,
    input  phtIndexT   headIndex,
    input  phtCounterT headCounter,
    output logic       popEn,
    output logic       predTaken [FETCH_WIDTH],
    output phtCounterT predCounter [FETCH_WIDTH],
    output logic       initDone
);

    // Counter storage.
    phtCounterT counterTable [PHT_ENTRY_NUM];

    // Initialization sequencer.
    initStateT initState;
    phtIndexT  initIndex;
    logic      initWrite;

    // Single write port.
    logic       tableWe;
    phtIndexT   tableWIndex;
    phtCounterT tableWCounter;

    // Read path.
    phtIndexT   readIndex [FETCH_WIDTH];
    phtCounterT readCounter [FETCH_WIDTH];
    logic       btbHitQ [FETCH_WIDTH];

    assign initWrite = (initState == INIT_RUN);
    assign initDone  = (initState == INIT_DONE);

    // One entry per cycle until the last index has been written.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            initState <= INIT_RUN;
            initIndex <= '0;
        end else if (initState == INIT_RUN) begin
            initIndex <= initIndex + 1'b1;
            if (initIndex == phtIndexT'(PHT_ENTRY_NUM - 1)) begin
                initState <= INIT_DONE;
            end
        end
    end

    // Queue drains only into otherwise idle write cycles.
    assign popEn = !queueEmpty && !directWe && !initWrite;

    // Priority is init, then direct, then queue head.
    always_comb begin
        tableWe       = 1'b0;
        tableWIndex   = headIndex;
        tableWCounter = headCounter;
        if (initWrite) begin
            tableWe       = 1'b1;
            tableWIndex   = initIndex;
            tableWCounter = phtCounterT'(COUNTER_INIT);
        end else if (directWe) begin
            tableWe       = 1'b1;
            tableWIndex   = directIndex;
            tableWCounter = directCounter;
        end else if (popEn) begin
            tableWe = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tableWe) begin
            counterTable[tableWIndex] <= tableWCounter;
        end
    end

    // Slot i looks at the instruction i words after predPc.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            readIndex[i] = phtIndexOf(predPc + pcT'(i * INSN_BYTES));
        end
    end

    // Read-before-write: a same-edge update is not visible yet.
    always_ff @(posedge clk) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            readCounter[i] <= counterTable[readIndex[i]];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                btbHitQ[i] <= 1'b0;
            end
        end else begin
            btbHitQ <= btbHit;
        end
    end

    // Counter MSB gives direction; nothing after a taken slot is fetched.
    always_comb begin
        logic blocked;

        blocked = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            predCounter[i] = readCounter[i];
            predTaken[i]   = !blocked && btbHitQ[i] && readCounter[i][COUNTER_WIDTH-1];
            blocked        = blocked || predTaken[i];
        end
    end

    // The resolver is expected to hold off until the table is filled.
    noUpdateDuringInit: assert property (
        @(posedge clk) disable iff (!arstN) (initState == INIT_RUN) |-> !directWe
    ) else $error("Branch update arrived during PHT initialization.");

endmodule

// ==== source/phtUpdateQueue.sv ====
/*
 * Four-entry circular FIFO of deferred PHT writes
 * (index and counter pairs) with drop-on-full pushes.
 */

`timescale 1ns/1ps

module phtUpdateQueue
    import bimodalPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       pushEn,
    input  phtIndexT   pushIndex,
    input  phtCounterT pushCounter,
    input  logic       popEn,
    output logic       queueEmpty,
    output phtIndexT   headIndex,
    output phtCounterT headCounter
);

    // Entry storage.
    phtIndexT   indexMem [QUEUE_DEPTH];
    phtCounterT counterMem [QUEUE_DEPTH];

    queuePtrT headPtr;
    queuePtrT tailPtr;
    logic [QUEUE_PTR_WIDTH:0] count;

    logic queueFull;
    logic doPush;
    logic doPop;

    assign queueEmpty = (count == '0);
    assign queueFull  = (count == QUEUE_DEPTH);

    // Predictor updates are only hints, so a push that finds no room is lost.
    assign doPush = pushEn && !queueFull;
    assign doPop  = popEn && !queueEmpty;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (doPop) begin
                headPtr <= headPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            indexMem[tailPtr]   <= pushIndex;
            counterMem[tailPtr] <= pushCounter;
        end
    end

    assign headIndex   = indexMem[headPtr];
    assign headCounter = counterMem[headPtr];

    // The table side must only pop what is there.
    noPopWhenEmpty: assert property (
        @(posedge clk) disable iff (!arstN) !(popEn && queueEmpty)
    ) else $error("Pop requested from an empty update queue.");

endmodule

// ==== source/phtUpdateResolver.sv ====
/*
 * Turns up to two resolved branches per cycle into one direct
 * PHT write and at most one deferred write for the update queue.
 */

`timescale 1ns/1ps

module phtUpdateResolver
    import bimodalPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       initDone,
    input  logic       brValid [RESOLVE_WIDTH],
    input  pcT         brPc [RESOLVE_WIDTH],
    input  logic       brTaken [RESOLVE_WIDTH],
    input  logic       brMispred [RESOLVE_WIDTH],
    input  phtCounterT brPrevCounter [RESOLVE_WIDTH],
    output logic       directWe,
    output phtIndexT   directIndex,
    output phtCounterT directCounter,
    output logic       pushEn,
    output phtIndexT   pushIndex,
    output phtCounterT pushCounter
);

    // Per-slot update candidates.
    logic       slotValid [RESOLVE_WIDTH];
    phtIndexT   slotIndex [RESOLVE_WIDTH];
    phtCounterT slotNext [RESOLVE_WIDTH];

    // Saturating step of a two-bit counter.
    function automatic phtCounterT satNext(input phtCounterT prev, input logic taken);
        phtCounterT result;
        if (taken) begin
            result = (prev == phtCounterT'(COUNTER_MAX)) ? prev : prev + 1'b1;
        end else begin
            result = (prev == '0) ? prev : prev - 1'b1;
        end
        return result;
    endfunction

    always_comb begin
        for (int i = 0; i < RESOLVE_WIDTH; i++) begin
            // Results arriving while the table is still being filled are dropped.
            slotValid[i] = brValid[i] && initDone;
            slotIndex[i] = phtIndexOf(brPc[i]);
            slotNext[i]  = satNext(brPrevCounter[i], brTaken[i]);
        end
    end

    // First valid slot claims the write port and the next one goes to the queue.
    // A mispredicted slot squashes everything younger than it.
    always_comb begin
        logic claimed;
        logic squash;

        claimed       = 1'b0;
        squash        = 1'b0;
        directWe      = 1'b0;
        directIndex   = slotIndex[0];
        directCounter = slotNext[0];
        pushEn        = 1'b0;
        pushIndex     = slotIndex[RESOLVE_WIDTH-1];
        pushCounter   = slotNext[RESOLVE_WIDTH-1];

        for (int i = 0; i < RESOLVE_WIDTH; i++) begin
            if (slotValid[i] && !squash) begin
                if (!claimed) begin
                    directWe      = 1'b1;
                    directIndex   = slotIndex[i];
                    directCounter = slotNext[i];
                    claimed       = 1'b1;
                end else begin
                    pushEn      = 1'b1;
                    pushIndex   = slotIndex[i];
                    pushCounter = slotNext[i];
                end
                squash = brMispred[i];
            end
        end
    end

    // A queued update is always the younger half of a pair.
    pushNeedsDirect: assert property (
        @(posedge clk) disable iff (!arstN)
            pushEn |-> directWe && brValid[0] && !brMispred[0] && brValid[1]
    ) else $error("Queue push without a direct write in the same cycle.");

endmodule

// ==== tests/bimodalPredictorTests.svh ====
/*
 * Directed tests: initialization, counter saturation, slot rules,
 * dual update with queue drain, mispredict cancel, queue overflow.
 */

task automatic initSequence();
    int waited;
    pcT pc;
    waited = 0;
    @(negedge clk);
    checkValue("initDone", initDone, 0);
    checkValue("predTaken[0]", predTaken[0], 0);
    while (!initDone && waited < PHT_ENTRY_NUM + 16) begin
        @(negedge clk);
        waited++;
    end
    if (!initDone) begin
        abortRun("initDone did not rise after the table initialization.");
    end
    for (int i = 0; i < 8; i++) begin
        pc = pcT'($random(seed)) & 32'hFFFF_FFFC;
        comparePrediction(pc, 1'b1, 1'b1);
        checkValue("predCounter[0]", predCounter[0], COUNTER_INIT);
    end
endtask

task automatic counterSaturation();
    pcT pc;
    pc = 32'h0000_0040;
    // Climb from the init value, then stay pinned at the top.
    for (int i = 0; i < 4; i++) begin
        comparePrediction(pc, 1'b1, 1'b0);
        resolveCycle(2'b01, 2'b01, 2'b00, pc, '0, predCounter[0], '0);
        releaseBranches();
    end
    comparePrediction(pc, 1'b1, 1'b0);
    checkValue("predCounter[0]", predCounter[0], COUNTER_MAX);
    for (int i = 0; i < 5; i++) begin
        resolveCycle(2'b01, 2'b00, 2'b00, pc, '0, predCounter[0], '0);
        releaseBranches();
        comparePrediction(pc, 1'b1, 1'b0);
    end
    checkValue("predCounter[0]", predCounter[0], 0);
endtask

task automatic slotRules();
    pcT pc;
    pc = 32'h0000_0100;
    comparePrediction(pc, 1'b0, 1'b0);
    checkValue("predTaken[1]", predTaken[1], 0);
    // Slot 1 counter is 2, but a taken slot 0 ends the fetch group.
    comparePrediction(pc, 1'b1, 1'b1);
    checkValue("predTaken[1]", predTaken[1], 0);
    comparePrediction(pc, 1'b0, 1'b1);
    checkValue("predTaken[1]", predTaken[1], 1);
endtask

task automatic dualUpdateDrain();
    pcT pcA;
    pcT pcB;
    pcA = 32'h0000_0200;
    pcB = 32'h0000_0300;
    resolveCycle(2'b11, 2'b01, 2'b00, pcA, pcB,
                 modelPht[tableIndex(pcA)], modelPht[tableIndex(pcB)]);
    releaseBranches();
    drainQueue();
    comparePrediction(pcA, 1'b0, 1'b0);
    comparePrediction(pcB, 1'b0, 1'b0);
    // Same index twice, so the queued value lands after the direct one.
    resolveCycle(2'b11, 2'b10, 2'b00, pcA, pcA,
                 modelPht[tableIndex(pcA)], modelPht[tableIndex(pcA)]);
    releaseBranches();
    drainQueue();
    comparePrediction(pcA, 1'b0, 1'b0);
    checkValue("predCounter[0]", predCounter[0], COUNTER_MAX);
endtask

task automatic mispredictCancel();
    pcT         pcA;
    phtCounterT saved;
    pcA   = 32'h0000_0280;
    saved = modelPht[tableIndex(pcA + INSN_BYTES)];
    resolveCycle(2'b11, 2'b10, 2'b01, pcA, pcA + INSN_BYTES,
                 modelPht[tableIndex(pcA)], saved);
    releaseBranches();
    drainQueue();
    comparePrediction(pcA, 1'b0, 1'b0);
    checkValue("predCounter[1]", predCounter[1], saved);
endtask

task automatic queueOverflow();
    pcT base;
    base = 32'h0000_0380;
    for (int i = 0; i < 6; i++) begin
        resolveCycle(2'b11, 2'b11, 2'b00, pcT'(base + 8 * i), pcT'(base + 8 * i + 4),
                     modelPht[tableIndex(pcT'(base + 8 * i))],
                     modelPht[tableIndex(pcT'(base + 8 * i + 4))]);
    end
    releaseBranches();
    drainQueue();
    // Only the first QUEUE_DEPTH slot 1 updates found room.
    for (int i = 0; i < 6; i++) begin
        comparePrediction(pcT'(base + 8 * i), 1'b0, 1'b0);
        checkValue("predCounter[1]", predCounter[1],
                   (i < QUEUE_DEPTH) ? COUNTER_MAX : COUNTER_INIT);
    end
endtask

// ==== tests/bimodalPredictorTb.sv ====
/*
 * Testbench top for the bimodal predictor: clock, reset, DUT,
 * reference model of table and update queue, check task,
 * stimulus helpers, watchdog and the test sequence.
 */

`timescale 1ns/1ps

module bimodalPredictorTb
    import bimodalPkg::*;
#(
    parameter int RANDOM_SEED = 39104
);

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 5;
    localparam int TEST_CYCLES    = 120;
    localparam int MARGIN_CYCLES  = 64;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + PHT_ENTRY_NUM + TEST_CYCLES + MARGIN_CYCLES;
    localparam int QENTRY_WIDTH   = PHT_INDEX_WIDTH + COUNTER_WIDTH;

    logic       clk;
    logic       arstN;
    pcT         predPc;
    logic       btbHit [FETCH_WIDTH];
    logic       brValid [RESOLVE_WIDTH];
    pcT         brPc [RESOLVE_WIDTH];
    logic       brTaken [RESOLVE_WIDTH];
    logic       brMispred [RESOLVE_WIDTH];
    phtCounterT brPrevCounter [RESOLVE_WIDTH];
    logic       predTaken [FETCH_WIDTH];
    phtCounterT predCounter [FETCH_WIDTH];
    logic       initDone;
    int         seed;

    // Reference model state, queue entries are {index, counter}.
    phtCounterT              modelPht [PHT_ENTRY_NUM];
    logic [QENTRY_WIDTH-1:0] modelQueue [$];

    bimodalPredictor i_bimodalPredictor (
        .clk, .arstN, .predPc, .btbHit,
        .brValid, .brPc, .brTaken, .brMispred, .brPrevCounter,
        .predTaken, .predCounter, .initDone
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Word address modulo the table size.
    function automatic phtIndexT tableIndex(input pcT pc);
        return phtIndexT'((pc / INSN_BYTES) % PHT_ENTRY_NUM);
    endfunction

    function automatic phtCounterT stepCounter(input phtCounterT prev, input logic taken);
        if (taken && prev != phtCounterT'(COUNTER_MAX)) begin
            return prev + 1'b1;
        end
        if (!taken && prev != '0) begin
            return prev - 1'b1;
        end
        return prev;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // Mirrors the single write port: direct write first, else one queue pop.
    always @(posedge clk) begin : referenceModel
        logic [QENTRY_WIDTH-1:0] entry;
        if (!arstN) begin
            for (int i = 0; i < PHT_ENTRY_NUM; i++) begin
                modelPht[i] = phtCounterT'(COUNTER_INIT);
            end
            modelQueue.delete();
        end else if (initDone) begin
            if (brValid[0]) begin
                modelPht[tableIndex(brPc[0])] = stepCounter(brPrevCounter[0], brTaken[0]);
                if (brValid[1] && !brMispred[0] && modelQueue.size() < QUEUE_DEPTH) begin
                    modelQueue.push_back({tableIndex(brPc[1]),
                                          stepCounter(brPrevCounter[1], brTaken[1])});
                end
            end else if (brValid[1]) begin
                modelPht[tableIndex(brPc[1])] = stepCounter(brPrevCounter[1], brTaken[1]);
            end else if (modelQueue.size() > 0) begin
                entry = modelQueue.pop_front();
                modelPht[entry[QENTRY_WIDTH-1:COUNTER_WIDTH]] = entry[COUNTER_WIDTH-1:0];
            end
        end
    end

    task automatic resolveCycle(input logic [1:0] valid, input logic [1:0] taken,
                                input logic [1:0] mispred, input pcT pc0, input pcT pc1,
                                input phtCounterT prev0, input phtCounterT prev1);
        @(posedge clk);
        brPc[0]          <= pc0;
        brPc[1]          <= pc1;
        brPrevCounter[0] <= prev0;
        brPrevCounter[1] <= prev1;
        for (int i = 0; i < RESOLVE_WIDTH; i++) begin
            brValid[i]   <= valid[i];
            brTaken[i]   <= taken[i];
            brMispred[i] <= mispred[i];
        end
    endtask

    task automatic releaseBranches();
        @(posedge clk);
        brValid[0] <= 1'b0;
        brValid[1] <= 1'b0;
    endtask

    task automatic drainQueue();
        int waited;
        waited = 0;
        @(negedge clk);
        while (modelQueue.size() > 0 && waited < 4 * QUEUE_DEPTH) begin
            @(negedge clk);
            waited++;
        end
        if (modelQueue.size() > 0) begin
            abortRun("The update queue did not drain in time.");
        end
    endtask

    // Present predPc, then sample the registered result mid-cycle.
    task automatic comparePrediction(input pcT pc, input logic hit0, input logic hit1);
        phtCounterT exp0;
        phtCounterT exp1;
        logic       taken0;
        logic       taken1;
        @(posedge clk);
        predPc    <= pc;
        btbHit[0] <= hit0;
        btbHit[1] <= hit1;
        @(posedge clk);
        @(negedge clk);
        exp0   = modelPht[tableIndex(pc)];
        exp1   = modelPht[tableIndex(pc + INSN_BYTES)];
        taken0 = hit0 && exp0[COUNTER_WIDTH-1];
        taken1 = hit1 && exp1[COUNTER_WIDTH-1] && !taken0;
        checkValue("predCounter[0]", predCounter[0], exp0);
        checkValue("predCounter[1]", predCounter[1], exp1);
        checkValue("predTaken[0]", predTaken[0], taken0);
        checkValue("predTaken[1]", predTaken[1], taken1);
    endtask

    `include "bimodalPredictorTests.svh"

    // Covers the init sweep plus all directed tests.
    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abortRun("Timeout: the tests did not finish within the cycle budget.");
    end

    initial begin : testSequence
        seed   = RANDOM_SEED;
        arstN  = 1'b0;
        predPc = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            btbHit[i] = 1'b0;
        end
        for (int i = 0; i < RESOLVE_WIDTH; i++) begin
            brValid[i]       = 1'b0;
            brPc[i]          = '0;
            brTaken[i]       = 1'b0;
            brMispred[i]     = 1'b0;
            brPrevCounter[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        initSequence();
        counterSaturation();
        slotRules();
        dualUpdateDrain();
        mispredictCancel();
        queueOverflow();
        $display("Everything OK");
        $finish;
    end

endmodule
